// File: files.f
design/icache_pkg.sv
design/icache_tag_store.sv
design/icache_data_store.sv
design/icache_lookup.sv
design/icache_refill.sv
design/icache_top.sv
dv/icache_mem_model.sv
dv/icache_tb.sv

// File: dv/icache_tb.sv
/* Testbench for the two-way instruction cache. Drives fetch sequences, predicts hits
   and lines with a reference model of the cache contents and reports one line per test. */
`timescale 1ns/10ps

module icache_tb;

    localparam int RESET_CYCLES = 8;
    localparam int MISS_CYCLES  = 20;
    localparam int FETCHES      = 16;
    localparam int CYCLE_LIMIT  = RESET_CYCLES + FETCHES * MISS_CYCLES + 40;

    // T1, T2 and T3 share set 8 with different tags.
    localparam icache_pkg::addr_t ADDR_A  = 64'h0000_1040;
    localparam icache_pkg::addr_t ADDR_B  = 64'h0000_2238;
    localparam icache_pkg::addr_t ADDR_T1 = 64'h0000_4088;
    localparam icache_pkg::addr_t ADDR_T2 = 64'h0000_8084;
    localparam icache_pkg::addr_t ADDR_T3 = 64'h0000_C08C;

    logic               clk;
    logic               arst_n_i;
    logic               req_valid_i;
    icache_pkg::addr_t  req_addr_i;
    logic               resp_ready_i;
    logic               fence_i;
    logic               mem_valid_i;
    icache_pkg::beat_t  mem_data_i;
    logic               req_ready_o;
    logic               resp_valid_o;
    icache_pkg::line_t  resp_data_o;
    icache_pkg::addr_t  resp_addr_o;
    logic               mem_req_o;
    icache_pkg::addr_t  mem_addr_o;

    icache_pkg::tag_t   ref_tag [icache_pkg::SETS][2];
    logic [1:0]         ref_valid [icache_pkg::SETS];
    bit                 ref_lru [icache_pkg::SETS];
    icache_pkg::addr_t  beat_addrs [$];
    int                 req_starts;
    logic               mem_req_prev;
    int                 errors = 0;
    int                 errors_before = 0;
    int                 tests_done = 0;
    int                 tests_failed = 0;
    int                 cycle_cnt;

    always #5 clk = ~clk;

    icache_top u_icache_top (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .req_valid_i  (req_valid_i),
        .req_addr_i   (req_addr_i),
        .resp_ready_i (resp_ready_i),
        .fence_i      (fence_i),
        .mem_valid_i  (mem_valid_i),
        .mem_data_i   (mem_data_i),
        .req_ready_o  (req_ready_o),
        .resp_valid_o (resp_valid_o),
        .resp_data_o  (resp_data_o),
        .resp_addr_o  (resp_addr_o),
        .mem_req_o    (mem_req_o),
        .mem_addr_o   (mem_addr_o)
    );

    icache_mem_model u_mem_model (
        .clk         (clk),
        .mem_req_i   (mem_req_o),
        .mem_addr_i  (mem_addr_o),
        .mem_valid_o (mem_valid_i),
        .mem_data_o  (mem_data_i)
    );

    // Counts refill requests and records the address of every beat taken.
    always @(posedge clk) begin
        if (mem_req_o && !mem_req_prev) begin
            req_starts++;
        end
        if (mem_req_o && mem_valid_i) begin
            beat_addrs.push_back(mem_addr_o);
        end
        mem_req_prev = mem_req_o;
    end

    // Beat at address A carries ~A[31:0] above A[31:0], beat 0 sits in the low half.
    function automatic icache_pkg::line_t line_of(input icache_pkg::addr_t a);
        logic [31:0] base;
        base = {a[31:4], 4'h0};
        return {~(base + 32'd8), base + 32'd8, ~base, base};
    endfunction

    // Tag compare over both ways, else fill the first invalid way or the LRU way.
    function automatic bit model_access(input icache_pkg::addr_t a);
        icache_pkg::index_t idx;
        icache_pkg::tag_t   tg;
        bit                 hit;
        bit                 way;
        idx = a[icache_pkg::OFFSET_W +: icache_pkg::INDEX_W];
        tg  = a[icache_pkg::OFFSET_W + icache_pkg::INDEX_W +: icache_pkg::TAG_W];
        hit = 1'b1;
        if (ref_valid[idx][0] && ref_tag[idx][0] == tg) begin
            way = 1'b0;
        end else if (ref_valid[idx][1] && ref_tag[idx][1] == tg) begin
            way = 1'b1;
        end else begin
            hit = 1'b0;
            way = ref_valid[idx][0] ? (ref_valid[idx][1] ? ref_lru[idx] : 1'b1) : 1'b0;
            ref_valid[idx][way] = 1'b1;
            ref_tag[idx][way]   = tg;
        end
        ref_lru[idx] = ~way;
        return hit;
    endfunction

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        assert (got === exp) else begin
            $display("ERR at %0t: %s = %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_true(input bit cond, input string what);
        assert (cond) else begin
            $display("Error at %0t: %s", $time, what);
            errors++;
        end
    endtask

    task automatic fetch(input icache_pkg::addr_t a, output bit miss_seen);
        bit exp_hit;
        int lat;
        exp_hit    = model_access(a);
        req_starts = 0;
        beat_addrs.delete();
        @(negedge clk);
        req_valid_i = 1'b1;
        req_addr_i  = a;
        @(posedge clk);
        while (!req_ready_o) @(posedge clk);
        @(negedge clk);
        req_valid_i = 1'b0;
        lat = 1;
        @(posedge clk);
        while (!resp_valid_o) begin
            lat++;
            @(posedge clk);
        end
        check_value("resp_data_o", resp_data_o, line_of(a));
        check_value("resp_addr_o", resp_addr_o, a);
        @(negedge clk);
        miss_seen = (req_starts != 0);
        if (exp_hit) begin
            check_true(lat == 1 && !miss_seen, "hit was not served in one cycle from the arrays");
        end else begin
            check_true(req_starts == 2 && beat_addrs.size() == 2,
                       "miss did not make exactly two memory requests");
            if (beat_addrs.size() == 2) begin
                check_value("mem_addr_o", beat_addrs[0], {a[63:4], 4'h0});
                check_value("mem_addr_o", beat_addrs[1], {a[63:4], 4'h8});
            end
        end
    endtask

    task automatic finish_test(input string name);
        tests_done++;
        if (errors == errors_before) begin
            $display("Test %0d %s: ok", tests_done, name);
        end else begin
            $display("Test %0d %s: %0d errors", tests_done, name, errors - errors_before);
            tests_failed++;
        end
        errors_before = errors;
    endtask

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        icache_pkg::addr_t seq [4];
        bit                stream_hit [4];
        bit                stall_hit;
        bit                next_hit;
        bit                missed;
        clk          = 1'b0;
        arst_n_i     = 1'b0;
        req_valid_i  = 1'b0;
        req_addr_i   = '0;
        resp_ready_i = 1'b1;
        fence_i      = 1'b0;
        mem_req_prev = 1'b0;
        for (int s = 0; s < icache_pkg::SETS; s++) begin
            ref_valid[s] = 2'b00;
        end
        repeat (RESET_CYCLES) @(negedge clk);
        arst_n_i = 1'b1;
        @(posedge clk);
        check_value("resp_valid_o", resp_valid_o, 1'b0);
        check_value("mem_req_o", mem_req_o, 1'b0);
        check_value("req_ready_o", req_ready_o, 1'b1);
        finish_test("reset");

        fetch(ADDR_A, missed);
        check_true(missed, "first fetch of a line did not refill");
        fetch(ADDR_B, missed);
        check_true(missed, "first fetch of a line did not refill");
        finish_test("miss refill");

        fetch(ADDR_A + 4, missed);
        check_true(!missed, "repeat fetch in the same line went to memory");
        fetch(ADDR_B - 4, missed);
        check_true(!missed, "repeat fetch in the same line went to memory");
        seq = '{ADDR_A, ADDR_B, ADDR_A + 12, ADDR_B - 4};
        for (int i = 0; i < 4; i++) begin
            stream_hit[i] = model_access(seq[i]);
        end
        for (int i = 0; i <= 4; i++) begin
            @(negedge clk);
            req_valid_i = (i < 4);
            req_addr_i  = seq[i % 4];
            @(posedge clk);
            check_true(req_ready_o || i == 4, "back-to-back hit was not accepted");
            if (i > 0) begin
                check_value("resp_valid_o", resp_valid_o, stream_hit[i-1]);
                check_value("resp_addr_o", resp_addr_o, seq[i-1]);
                check_value("resp_data_o", resp_data_o, line_of(seq[i-1]));
            end
        end
        finish_test("hits");

        fetch(ADDR_T1, missed);
        fetch(ADDR_T2, missed);
        fetch(ADDR_T2, missed);
        check_true(!missed, "second way lost its line");
        fetch(ADDR_T1, missed);
        check_true(!missed, "first way lost its line");
        fetch(ADDR_T3, missed);
        fetch(ADDR_T1, missed);
        check_true(!missed, "recently used line was evicted");
        fetch(ADDR_T2, missed);
        check_true(missed, "least recently used line was not evicted");
        finish_test("ways and lru");

        @(negedge clk);
        fence_i = 1'b1;
        @(posedge clk);
        check_value("req_ready_o", req_ready_o, 1'b0);
        @(negedge clk);
        fence_i = 1'b0;
        for (int s = 0; s < icache_pkg::SETS; s++) begin
            ref_valid[s] = 2'b00;
        end
        seq = '{ADDR_A, ADDR_B, ADDR_T1, ADDR_T2};
        for (int i = 0; i < 4; i++) begin
            fetch(seq[i], missed);
            check_true(missed, "line still cached after fence");
        end
        finish_test("fence");

        stall_hit = model_access(ADDR_A);
        next_hit  = model_access(ADDR_B);
        @(negedge clk);
        resp_ready_i = 1'b0;
        req_valid_i  = 1'b1;
        req_addr_i   = ADDR_A;
        @(posedge clk);
        while (!req_ready_o) @(posedge clk);
        @(negedge clk);
        req_addr_i = ADDR_B;
        for (int i = 0; i < 5; i++) begin
            @(posedge clk);
            check_value("resp_valid_o", resp_valid_o, stall_hit);
            check_value("resp_data_o", resp_data_o, line_of(ADDR_A));
            check_value("resp_addr_o", resp_addr_o, ADDR_A);
            check_value("req_ready_o", req_ready_o, 1'b0);
            @(negedge clk);
        end
        resp_ready_i = 1'b1;
        @(posedge clk);
        check_value("req_ready_o", req_ready_o, 1'b1);
        @(negedge clk);
        req_valid_i = 1'b0;
        @(posedge clk);
        check_value("resp_valid_o", resp_valid_o, next_hit);
        check_value("resp_addr_o", resp_addr_o, ADDR_B);
        check_value("resp_data_o", resp_data_o, line_of(ADDR_B));
        finish_test("back-pressure");

        $display("Summary: %0d tests, %0d failed, %0d errors", tests_done, tests_failed, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: dv/icache_mem_model.sv
/* Backing memory for the instruction cache testbench.
   Answers each refill request with one beat after a pseudo-random delay of 1 to 4 cycles. */
`timescale 1ns/10ps

module icache_mem_model (
    input  logic               clk,
    input  logic               mem_req_i,
    input  icache_pkg::addr_t  mem_addr_i,
    output logic               mem_valid_o,
    output icache_pkg::beat_t  mem_data_o
);

    logic [31:0] lcg_state;
    int          wait_cnt;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    initial begin
        lcg_state   = 32'ha0ad;
        wait_cnt    = 0;
        mem_valid_o = 1'b0;
        mem_data_o  = '0;
    end

    // One beat per request, shown for a single cycle.
    always @(negedge clk) begin
        if (mem_valid_o) begin
            mem_valid_o = 1'b0;
        end else if (wait_cnt > 0) begin
            wait_cnt--;
            if (wait_cnt == 0) begin
                mem_valid_o = 1'b1;
                mem_data_o  = {~mem_addr_i[31:0], mem_addr_i[31:0]};
            end
        end else if (mem_req_i === 1'b1) begin
            lcg_state = lcg_next(lcg_state);
            wait_cnt  = 1 + lcg_state[17:16];
        end
    end

endmodule

// File: design/icache_top.sv
/* Two-way instruction cache top level with a fetch port and a two-beat refill port.
   Ties the tag and data stores to the lookup stage and the refill engine. */
`timescale 1ns/10ps

module icache_top (
    input  logic               clk,
    input  logic               arst_n_i,
    input  logic               req_valid_i,
    input  icache_pkg::addr_t  req_addr_i,
    input  logic               resp_ready_i,
    input  logic               fence_i,
    input  logic               mem_valid_i,
    input  icache_pkg::beat_t  mem_data_i,
    output logic               req_ready_o,
    output logic               resp_valid_o,
    output icache_pkg::line_t  resp_data_o,
    output icache_pkg::addr_t  resp_addr_o,
    output logic               mem_req_o,
    output icache_pkg::addr_t  mem_addr_o
);

    logic                        rd_en;
    icache_pkg::index_t          rd_index;
    icache_pkg::tag_t            tag0;
    icache_pkg::tag_t            tag1;
    logic                        valid0;
    logic                        valid1;
    icache_pkg::line_t           line0;
    icache_pkg::line_t           line1;
    logic                        lru_way;
    logic [icache_pkg::WAYS-1:0] set_valid;
    logic                        hit_en;
    logic                        hit_way;
    logic                        miss_start;
    icache_pkg::addr_t           miss_addr;
    logic                        fill_en;
    logic                        fill_way;
    icache_pkg::index_t          fill_index;
    icache_pkg::tag_t            fill_tag;
    icache_pkg::line_t           fill_line;
    logic                        fill_done;

    icache_tag_store u_tag_store (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .rd_en_i      (rd_en),
        .rd_index_i   (rd_index),
        .hit_en_i     (hit_en),
        .hit_way_i    (hit_way),
        .fill_en_i    (fill_en),
        .fill_way_i   (fill_way),
        .fill_index_i (fill_index),
        .fill_tag_i   (fill_tag),
        .fence_i      (fence_i),
        .tag0_o       (tag0),
        .tag1_o       (tag1),
        .valid0_o     (valid0),
        .valid1_o     (valid1),
        .lru_way_o    (lru_way),
        .set_valid_o  (set_valid)
    );

    icache_data_store u_data_store (
        .clk          (clk),
        .rd_en_i      (rd_en),
        .rd_index_i   (rd_index),
        .fill_en_i    (fill_en),
        .fill_way_i   (fill_way),
        .fill_index_i (fill_index),
        .fill_line_i  (fill_line),
        .line0_o      (line0),
        .line1_o      (line1)
    );

    icache_lookup u_lookup (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .req_valid_i  (req_valid_i),
        .req_addr_i   (req_addr_i),
        .resp_ready_i (resp_ready_i),
        .fence_i      (fence_i),
        .tag0_i       (tag0),
        .tag1_i       (tag1),
        .valid0_i     (valid0),
        .valid1_i     (valid1),
        .line0_i      (line0),
        .line1_i      (line1),
        .fill_done_i  (fill_done),
        .fill_line_i  (fill_line),
        .req_ready_o  (req_ready_o),
        .rd_en_o      (rd_en),
        .rd_index_o   (rd_index),
        .resp_valid_o (resp_valid_o),
        .resp_data_o  (resp_data_o),
        .resp_addr_o  (resp_addr_o),
        .hit_en_o     (hit_en),
        .hit_way_o    (hit_way),
        .miss_start_o (miss_start),
        .miss_addr_o  (miss_addr)
    );

    icache_refill u_refill (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .miss_start_i (miss_start),
        .miss_addr_i  (miss_addr),
        .set_valid_i  (set_valid),
        .lru_way_i    (lru_way),
        .mem_valid_i  (mem_valid_i),
        .mem_data_i   (mem_data_i),
        .mem_req_o    (mem_req_o),
        .mem_addr_o   (mem_addr_o),
        .fill_en_o    (fill_en),
        .fill_way_o   (fill_way),
        .fill_index_o (fill_index),
        .fill_tag_o   (fill_tag),
        .fill_line_o  (fill_line),
        .fill_done_o  (fill_done)
    );

endmodule

// File: design/icache_refill.sv
/* Refill engine for cache misses. Fetches a line as two 64-bit beats,
   picks the victim way and writes tag and line in one cycle. */
`timescale 1ns/10ps

module icache_refill (
    input  logic                          clk,
    input  logic                          arst_n_i,
    input  logic                          miss_start_i,
    input  icache_pkg::addr_t             miss_addr_i,
    input  logic [icache_pkg::WAYS-1:0]   set_valid_i,
    input  logic                          lru_way_i,
    input  logic                          mem_valid_i,
    input  icache_pkg::beat_t             mem_data_i,
    output logic                          mem_req_o,
    output icache_pkg::addr_t             mem_addr_o,
    output logic                          fill_en_o,
    output logic                          fill_way_o,
    output icache_pkg::index_t            fill_index_o,
    output icache_pkg::tag_t              fill_tag_o,
    output icache_pkg::line_t             fill_line_o,
    output logic                          fill_done_o
);

    icache_pkg::refill_state_e state_q;
    logic                      mem_req_q;
    icache_pkg::addr_t         miss_addr_q;
    icache_pkg::line_t         line_q;
    logic                      beat0_take;
    logic                      beat1_take;
    logic                      victim_way;

    assign beat0_take = (state_q == icache_pkg::BEAT0) && mem_valid_i;
    assign beat1_take = (state_q == icache_pkg::BEAT1) && mem_req_q && mem_valid_i;

    // Request drops for one cycle between the two beats.
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q   <= icache_pkg::IDLE;
            mem_req_q <= 1'b0;
        end else begin
            case (state_q)
                icache_pkg::IDLE: begin
                    if (miss_start_i) begin
                        state_q   <= icache_pkg::BEAT0;
                        mem_req_q <= 1'b1;
                    end
                end
                icache_pkg::BEAT0: begin
                    if (beat0_take) begin
                        state_q   <= icache_pkg::BEAT1;
                        mem_req_q <= 1'b0;
                    end
                end
                icache_pkg::BEAT1: begin
                    if (!mem_req_q) begin
                        mem_req_q <= 1'b1;
                    end else if (beat1_take) begin
                        state_q   <= icache_pkg::DONE;
                        mem_req_q <= 1'b0;
                    end
                end
                icache_pkg::DONE: begin
                    state_q <= icache_pkg::IDLE;
                end
                default: begin
                    state_q <= icache_pkg::IDLE;
                end
            endcase
        end
    end

    // Beat 0 is the low half of the line.
    always_ff @(posedge clk) begin
        if ((state_q == icache_pkg::IDLE) && miss_start_i) begin
            miss_addr_q <= miss_addr_i;
        end
        if (beat0_take) begin
            line_q[icache_pkg::BEAT_W-1:0] <= mem_data_i;
        end
        if (beat1_take) begin
            line_q[icache_pkg::LINE_W-1:icache_pkg::BEAT_W] <= mem_data_i;
        end
    end

    // Lowest invalid way first, otherwise the least recently used one.
    always_comb begin
        if (!set_valid_i[0]) begin
            victim_way = 1'b0;
        end else if (!set_valid_i[1]) begin
            victim_way = 1'b1;
        end else begin
            victim_way = lru_way_i;
        end
    end

    assign mem_req_o  = mem_req_q;
    assign mem_addr_o = {miss_addr_q[icache_pkg::ADDR_W-1:icache_pkg::OFFSET_W],
                         (state_q == icache_pkg::BEAT1),
                         {(icache_pkg::OFFSET_W-1){1'b0}}};

    assign fill_en_o    = (state_q == icache_pkg::DONE);
    assign fill_done_o  = (state_q == icache_pkg::DONE);
    assign fill_way_o   = victim_way;
    assign fill_index_o = miss_addr_q[icache_pkg::OFFSET_W +: icache_pkg::INDEX_W];
    assign fill_tag_o   = miss_addr_q[icache_pkg::OFFSET_W + icache_pkg::INDEX_W +:
                                      icache_pkg::TAG_W];
    assign fill_line_o  = line_q;

endmodule

// File: design/icache_lookup.sv
/* Stage 2 of the fetch pipeline: tag compare, line select and response handshake.
   Also decides request acceptance and hands misses to the refill engine. */
`timescale 1ns/10ps

module icache_lookup (
    input  logic                clk,
    input  logic                arst_n_i,
    input  logic                req_valid_i,
    input  icache_pkg::addr_t   req_addr_i,
    input  logic                resp_ready_i,
    input  logic                fence_i,
    input  icache_pkg::tag_t    tag0_i,
    input  icache_pkg::tag_t    tag1_i,
    input  logic                valid0_i,
    input  logic                valid1_i,
    input  icache_pkg::line_t   line0_i,
    input  icache_pkg::line_t   line1_i,
    input  logic                fill_done_i,
    input  icache_pkg::line_t   fill_line_i,
    output logic                req_ready_o,
    output logic                rd_en_o,
    output icache_pkg::index_t  rd_index_o,
    output logic                resp_valid_o,
    output icache_pkg::line_t   resp_data_o,
    output icache_pkg::addr_t   resp_addr_o,
    output logic                hit_en_o,
    output logic                hit_way_o,
    output logic                miss_start_o,
    output icache_pkg::addr_t   miss_addr_o
);

    logic              s2_valid_q;
    logic              s2_missed_q;
    logic              s2_filled_q;
    icache_pkg::addr_t s2_addr_q;
    icache_pkg::tag_t  s2_tag;
    logic              hit0;
    logic              hit1;
    logic              hit;
    logic              accept;
    logic              resp_fire;

    assign s2_tag = s2_addr_q[icache_pkg::OFFSET_W + icache_pkg::INDEX_W +: icache_pkg::TAG_W];

    assign hit0 = valid0_i && (tag0_i == s2_tag);
    assign hit1 = valid1_i && (tag1_i == s2_tag);
    assign hit  = s2_valid_q && (hit0 || hit1);

    // After a refill the array outputs are stale, so the refill line is shown.
    assign resp_valid_o = s2_valid_q && (s2_filled_q || hit);
    assign resp_data_o  = s2_filled_q ? fill_line_i : (hit1 ? line1_i : line0_i);
    assign resp_addr_o  = s2_addr_q;
    assign resp_fire    = resp_valid_o && resp_ready_i;

    // Accept when stage 2 drains this cycle or is empty.
    assign req_ready_o = !fence_i && (!s2_valid_q || resp_fire);
    assign accept      = req_valid_i && req_ready_o;
    assign rd_en_o     = accept;
    assign rd_index_o  = req_addr_i[icache_pkg::OFFSET_W +: icache_pkg::INDEX_W];

    assign hit_en_o  = resp_fire && !s2_filled_q;
    assign hit_way_o = hit1;

    // One refill per miss.
    assign miss_start_o = s2_valid_q && !hit && !s2_missed_q;
    assign miss_addr_o  = s2_addr_q;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            s2_valid_q  <= 1'b0;
            s2_missed_q <= 1'b0;
            s2_filled_q <= 1'b0;
        end else if (accept) begin
            s2_valid_q  <= 1'b1;
            s2_missed_q <= 1'b0;
            s2_filled_q <= 1'b0;
        end else begin
            if (resp_fire) begin
                s2_valid_q <= 1'b0;
            end
            if (miss_start_o) begin
                s2_missed_q <= 1'b1;
            end
            if (fill_done_i) begin
                s2_filled_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            s2_addr_q <= req_addr_i;
        end
    end

endmodule

// File: design/icache_data_store.sv
/* Line storage for both cache ways, 64 lines of 128 bits each.
   Read is registered on rd_en_i and a refill writes one way. */
`timescale 1ns/10ps

module icache_data_store (
    input  logic                clk,
    input  logic                rd_en_i,
    input  icache_pkg::index_t  rd_index_i,
    input  logic                fill_en_i,
    input  logic                fill_way_i,
    input  icache_pkg::index_t  fill_index_i,
    input  icache_pkg::line_t   fill_line_i,
    output icache_pkg::line_t   line0_o,
    output icache_pkg::line_t   line1_o
);

    icache_pkg::line_t mem_q [icache_pkg::WAYS][icache_pkg::SETS];

    always_ff @(posedge clk) begin
        if (fill_en_i) begin
            mem_q[fill_way_i][fill_index_i] <= fill_line_i;
        end
    end

    // Outputs hold between reads so a stalled response stays steady.
    always_ff @(posedge clk) begin
        if (rd_en_i) begin
            line0_o <= mem_q[0][rd_index_i];
            line1_o <= mem_q[1][rd_index_i];
        end
    end

endmodule

// File: design/icache_tag_store.sv
/* Tag, valid and LRU state for both ways of the instruction cache.
   Gives a registered read of the fetched set and a direct view of the refill set. */
`timescale 1ns/10ps

module icache_tag_store (
    input  logic                          clk,
    input  logic                          arst_n_i,
    input  logic                          rd_en_i,
    input  icache_pkg::index_t            rd_index_i,
    input  logic                          hit_en_i,
    input  logic                          hit_way_i,
    input  logic                          fill_en_i,
    input  logic                          fill_way_i,
    input  icache_pkg::index_t            fill_index_i,
    input  icache_pkg::tag_t              fill_tag_i,
    input  logic                          fence_i,
    output icache_pkg::tag_t              tag0_o,
    output icache_pkg::tag_t              tag1_o,
    output logic                          valid0_o,
    output logic                          valid1_o,
    output logic                          lru_way_o,
    output logic [icache_pkg::WAYS-1:0]   set_valid_o
);

    icache_pkg::tag_t            tag_q [icache_pkg::WAYS][icache_pkg::SETS];
    logic [icache_pkg::WAYS-1:0] valid_q [icache_pkg::SETS];
    logic [icache_pkg::SETS-1:0] lru_q;

    // Set held by stage 2, used for the LRU update on a hit.
    icache_pkg::index_t          rd_index_q;

    always_ff @(posedge clk) begin
        if (fill_en_i) begin
            tag_q[fill_way_i][fill_index_i] <= fill_tag_i;
        end
    end

    // Valid and LRU bits. Fence clears every line in one cycle.
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int s = 0; s < icache_pkg::SETS; s++) begin
                valid_q[s] <= '0;
            end
            lru_q <= '0;
        end else if (fence_i) begin
            for (int s = 0; s < icache_pkg::SETS; s++) begin
                valid_q[s] <= '0;
            end
        end else if (fill_en_i) begin
            valid_q[fill_index_i][fill_way_i] <= 1'b1;
            lru_q[fill_index_i]               <= ~fill_way_i;
        end else if (hit_en_i) begin
            lru_q[rd_index_q] <= ~hit_way_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en_i) begin
            tag0_o     <= tag_q[0][rd_index_i];
            tag1_o     <= tag_q[1][rd_index_i];
            rd_index_q <= rd_index_i;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid0_o <= 1'b0;
            valid1_o <= 1'b0;
        end else if (rd_en_i) begin
            valid0_o <= valid_q[rd_index_i][0];
            valid1_o <= valid_q[rd_index_i][1];
        end
    end

    // Victim choice looks at the refill set directly.
    assign set_valid_o = valid_q[fill_index_i];
    assign lru_way_o   = lru_q[fill_index_i];

endmodule

// File: design/icache_pkg.sv
/* Shared geometry, vector types and refill states for the two-way instruction cache.
   Every cache module refers to these definitions by scoped name. */
package icache_pkg;

    // Address and data widths.
    localparam int ADDR_W   = 64;
    localparam int LINE_W   = 128;
    localparam int BEAT_W   = 64;

    // Cache geometry.
    localparam int SETS     = 64;
    localparam int INDEX_W  = 6;
    localparam int OFFSET_W = 4;
    localparam int TAG_W    = 22;
    localparam int WAYS     = 2;

    typedef logic [ADDR_W-1:0]  addr_t;
    typedef logic [LINE_W-1:0]  line_t;
    typedef logic [BEAT_W-1:0]  beat_t;
    typedef logic [TAG_W-1:0]   tag_t;
    typedef logic [INDEX_W-1:0] index_t;

    // Refill sequence, one state per beat plus a write cycle.
    typedef enum logic [1:0] {
        IDLE,
        BEAT0,
        BEAT1,
        DONE
    } refill_state_e;

endpackage
